//--- logic/spu_decode_pkg.sv
`default_nettype none

package spu_decode_pkg;

	localparam int INSTR_W    = 32;
	localparam int REG_ADDR_W = 7;

	localparam int IMM7_W  = 7;
	localparam int IMM10_W = 10;
	localparam int IMM16_W = 16;
	localparam int IMM18_W = 18;

	// opcode widths of the five formats
	localparam int OP4_W  = 4;
	localparam int OP7_W  = 7;
	localparam int OP8_W  = 8;
	localparam int OP9_W  = 9;
	localparam int OP11_W = 11;

	localparam int RT_LSB     = 25;
	localparam int RT_MSB     = 31;
	localparam int RRR_RT_LSB = 4; // rrr moves rt down to make room for rc
	localparam int RRR_RT_MSB = 10;
	localparam int RA_LSB     = 18;
	localparam int RA_MSB     = 24;
	localparam int RB_LSB     = 11;
	localparam int RB_MSB     = 17;
	localparam int RC_LSB     = 25;
	localparam int RC_MSB     = 31;
	localparam int IMM7_LSB   = 11; // shares the rb field
	localparam int IMM7_MSB   = 17;
	localparam int IMM10_LSB  = 8;
	localparam int IMM10_MSB  = 17;
	localparam int IMM16_LSB  = 9;
	localparam int IMM16_MSB  = 24;
	localparam int IMM18_LSB  = 7;
	localparam int IMM18_MSB  = 24;

	typedef enum logic [2:0] {
		UNIT_NONE = 3'd0,
		UNIT_FX1  = 3'd1, // simple fixed point
		UNIT_FX2  = 3'd2, // shift and rotate
		UNIT_SP   = 3'd3, // multiply and float
		UNIT_BYTE = 3'd4,
		UNIT_PERM = 3'd5, // quadword shift, rotate, gather
		UNIT_LS   = 3'd6, // local store
		UNIT_BR   = 3'd7
	} unit_e;

	typedef enum logic [OP4_W-1:0] {
		RRR_MPYA = 4'b1100,
		RRR_FMA  = 4'b1110,
		RRR_FMS  = 4'b1111
	} rrr_op_e;

	typedef enum logic [OP7_W-1:0] {
		RI18_ILA = 7'b0100001
	} ri18_op_e;

	typedef enum logic [OP8_W-1:0] {
		RI10_AHI = 8'b00011101, RI10_AI = 8'b00011100,
		RI10_SFHI = 8'b00001101, RI10_SFI = 8'b00001100,
		RI10_ANDHI = 8'b00010101, RI10_ANDI = 8'b00010100,
		RI10_ORHI = 8'b00000101, RI10_ORI = 8'b00000100,
		RI10_XORHI = 8'b01000101, RI10_XORI = 8'b01000100,
		RI10_CEQHI = 8'b01111101, RI10_CEQI = 8'b01111100,
		RI10_CGTHI = 8'b01001101, RI10_CGTI = 8'b01001100,
		RI10_CLGTHI = 8'b01011101, RI10_CLGTI = 8'b01011100,
		RI10_ANDBI = 8'b00010110, RI10_CEQBI = 8'b01111110,
		RI10_MPYI = 8'b01110100, RI10_MPYUI = 8'b01110101,
		RI10_LQD = 8'b00110100, RI10_STQD = 8'b00100100
	} ri10_op_e;

	typedef enum logic [OP9_W-1:0] {
		RI16_ILH = 9'b010000011, RI16_ILHU = 9'b010000010,
		RI16_IL = 9'b010000001, RI16_IOHL = 9'b011000001,
		RI16_LQA = 9'b001100001, RI16_BRNZ = 9'b001000010,
		RI16_BRHNZ = 9'b001000110, RI16_BRZ = 9'b001000000,
		RI16_BRA = 9'b001100000, RI16_BR = 9'b001100100
	} ri16_op_e;

	typedef enum logic [OP11_W-1:0] {
		RR_AH = 11'b00011001000, RR_A = 11'b00011000000,
		RR_SFH = 11'b00001001000, RR_SF = 11'b00001000000,
		RR_CG = 11'b00011000010, RR_CLZ = 11'b01010100101,
		RR_AND = 11'b00011000001, RR_ANDC = 11'b01011000001,
		RR_OR = 11'b00001000001, RR_ORC = 11'b01011001001,
		RR_XOR = 11'b01001000001, RR_NAND = 11'b00011001001,
		RR_NOR = 11'b00001001001, RR_CEQH = 11'b01111001000,
		RR_CEQ = 11'b01111000000, RR_CGTH = 11'b01001001000,
		RR_CGT = 11'b01001000000, RR_CLGTH = 11'b01011001000,
		RR_CLGT = 11'b01011000000, RR_SHLH = 11'b00001011111,
		RR_SHLHI = 11'b00001111111, RR_SHL = 11'b00001011011,
		RR_SHLI = 11'b00001111011, RR_ROTH = 11'b00001011100,
		RR_ROTHI = 11'b00001111100, RR_ROT = 11'b00001011000,
		RR_ROTI = 11'b00001111000, RR_MPY = 11'b01111000100,
		RR_MPYU = 11'b01111001100, RR_FA = 11'b01011000100,
		RR_FS = 11'b01011000101, RR_FM = 11'b01011000110,
		RR_AVGB = 11'b00011010011, RR_CNTB = 11'b01010110100,
		RR_ABSDB = 11'b00001010011, RR_SUMB = 11'b01001010011,
		RR_CEQB = 11'b01111010000, RR_SHLQBI = 11'b00111011011,
		RR_SHLQBII = 11'b00111111011, RR_SHLQBY = 11'b00111011111,
		RR_SHLQBYI = 11'b00111111111, RR_SHLQBYBI = 11'b00111001111,
		RR_ROTQBY = 11'b00111011100, RR_ROTQBYI = 11'b00111111100,
		RR_ROTQBI = 11'b00111011000, RR_ROTQBII = 11'b00111111000,
		RR_GBB = 11'b00110110010, RR_GBH = 11'b00110110001,
		RR_GB = 11'b00110110000, RR_STQX = 11'b00101000100,
		RR_LNOP = 11'b00000000001, RR_NOP = 11'b01000000001,
		RR_STOP = 11'b00000000000
	} rr_op_e;

endpackage

`default_nettype wire

//--- logic/rrr_form_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rrr_form_decoder (
	input  wire logic [spu_decode_pkg::INSTR_W-1:0]    instr,
	output logic                                        hit,
	output logic                                        use_ra,
	output logic                                        use_rb,
	output logic                                        use_rc,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rt,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      ra,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rb,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rc,
	output spu_decode_pkg::unit_e                       unit
);
	import spu_decode_pkg::*;

	rrr_op_e op;

	assign op = rrr_op_e'(instr[OP4_W-1:0]);

	always_comb begin
		case (op)
			RRR_MPYA, RRR_FMA, RRR_FMS: hit = 1'b1;
			default: hit = 1'b0;
		endcase
	end

	// three sources plus target, all on the sp unit
	assign rt     = hit ? instr[RRR_RT_MSB:RRR_RT_LSB] : '0;
	assign ra     = hit ? instr[RA_MSB:RA_LSB] : '0;
	assign rb     = hit ? instr[RB_MSB:RB_LSB] : '0;
	assign rc     = hit ? instr[RC_MSB:RC_LSB] : '0;
	assign use_ra = hit;
	assign use_rb = hit;
	assign use_rc = hit;
	assign unit   = hit ? UNIT_SP : UNIT_NONE;

endmodule

`default_nettype wire

//--- logic/imm_form_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module imm_form_decoder (
	input  wire logic [spu_decode_pkg::INSTR_W-1:0]    instr,
	output logic                                        hit,
	output logic                                        use_ra,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rt,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      ra,
	output spu_decode_pkg::unit_e                       unit,
	output logic [spu_decode_pkg::IMM10_W-1:0]         imm10,
	output logic [spu_decode_pkg::IMM16_W-1:0]         imm16,
	output logic [spu_decode_pkg::IMM18_W-1:0]         imm18
);
	import spu_decode_pkg::*;

	ri18_op_e op7;
	ri10_op_e op8;
	ri16_op_e op9;
	logic     hit7;
	logic     hit8;
	logic     hit9;
	unit_e    unit8;
	unit_e    unit9;

	assign op7 = ri18_op_e'(instr[OP7_W-1:0]);
	assign op8 = ri10_op_e'(instr[OP8_W-1:0]);
	assign op9 = ri16_op_e'(instr[OP9_W-1:0]);

	always_comb begin
		case (op7)
			RI18_ILA: hit7 = 1'b1;
			default:  hit7 = 1'b0;
		endcase
	end

	always_comb begin
		hit8  = 1'b1;
		unit8 = UNIT_FX1;
		case (op8)
			RI10_AHI, RI10_AI, RI10_SFHI, RI10_SFI,
			RI10_ANDHI, RI10_ANDI, RI10_ORHI, RI10_ORI,
			RI10_XORHI, RI10_XORI, RI10_CEQHI, RI10_CEQI,
			RI10_CGTHI, RI10_CGTI, RI10_CLGTHI, RI10_CLGTI,
			RI10_ANDBI, RI10_CEQBI, RI10_MPYI, RI10_MPYUI: unit8 = UNIT_FX1;
			RI10_LQD, RI10_STQD: unit8 = UNIT_LS; // d-form quadword access
			default: begin
				hit8  = 1'b0;
				unit8 = UNIT_NONE;
			end
		endcase
	end

	always_comb begin
		hit9  = 1'b1;
		unit9 = UNIT_FX1;
		case (op9)
			RI16_ILH, RI16_ILHU, RI16_IL, RI16_IOHL: unit9 = UNIT_FX1;
			RI16_LQA: unit9 = UNIT_LS;
			RI16_BRNZ, RI16_BRHNZ, RI16_BRZ,
			RI16_BRA, RI16_BR: unit9 = UNIT_BR;
			default: begin
				hit9  = 1'b0;
				unit9 = UNIT_NONE;
			end
		endcase
	end

	// shortest opcode wins when formats overlap
	always_comb begin
		hit    = 1'b0;
		use_ra = 1'b0;
		rt     = '0;
		ra     = '0;
		unit   = UNIT_NONE;
		imm10  = '0;
		imm16  = '0;
		imm18  = '0;
		if (hit7) begin
			hit   = 1'b1;
			rt    = instr[RT_MSB:RT_LSB];
			imm18 = instr[IMM18_MSB:IMM18_LSB];
			unit  = UNIT_FX1;
		end else if (hit8) begin
			hit    = 1'b1;
			use_ra = 1'b1; // only ri10 has a register source
			rt     = instr[RT_MSB:RT_LSB];
			ra     = instr[RA_MSB:RA_LSB];
			imm10  = instr[IMM10_MSB:IMM10_LSB];
			unit   = unit8;
		end else if (hit9) begin
			hit   = 1'b1;
			rt    = instr[RT_MSB:RT_LSB];
			imm16 = instr[IMM16_MSB:IMM16_LSB];
			unit  = unit9;
		end
	end

endmodule

`default_nettype wire

//--- logic/rr_form_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rr_form_decoder (
	input  wire logic [spu_decode_pkg::INSTR_W-1:0]    instr,
	output logic                                        hit,
	output logic                                        use_ra,
	output logic                                        use_rb,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rt,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      ra,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rb,
	output logic [spu_decode_pkg::IMM7_W-1:0]          imm7,
	output spu_decode_pkg::unit_e                       unit
);
	import spu_decode_pkg::*;

	rr_op_e op;
	logic   op_hit;
	logic   ra_only; // ri7 or single source, rb field holds imm7
	logic   no_regs; // lnop, nop, stop
	unit_e  op_unit;

	assign op = rr_op_e'(instr[OP11_W-1:0]);

	always_comb begin
		op_hit  = 1'b1;
		ra_only = 1'b0;
		no_regs = 1'b0;
		op_unit = UNIT_NONE;
		case (op)
			RR_AH, RR_A, RR_SFH, RR_SF, RR_CG,
			RR_AND, RR_ANDC, RR_OR, RR_ORC, RR_XOR, RR_NAND, RR_NOR,
			RR_CEQH, RR_CEQ, RR_CGTH, RR_CGT, RR_CLGTH, RR_CLGT: begin
				op_unit = UNIT_FX1;
			end
			RR_CLZ: begin
				op_unit = UNIT_FX1;
				ra_only = 1'b1;
			end
			RR_SHLH, RR_SHL, RR_ROTH, RR_ROT: begin
				op_unit = UNIT_FX2;
			end
			RR_SHLHI, RR_SHLI, RR_ROTHI, RR_ROTI: begin
				op_unit = UNIT_FX2;
				ra_only = 1'b1;
			end
			RR_MPY, RR_MPYU, RR_FA, RR_FS, RR_FM, RR_AVGB: begin
				op_unit = UNIT_SP;
			end
			RR_CNTB: begin
				op_unit = UNIT_SP;
				ra_only = 1'b1;
			end
			RR_ABSDB, RR_SUMB, RR_CEQB: begin
				op_unit = UNIT_BYTE;
			end
			RR_SHLQBI, RR_SHLQBY, RR_SHLQBYBI, RR_ROTQBY, RR_ROTQBI: begin
				op_unit = UNIT_PERM;
			end
			RR_SHLQBII, RR_SHLQBYI, RR_ROTQBYI, RR_ROTQBII,
			RR_GBB, RR_GBH, RR_GB: begin
				op_unit = UNIT_PERM;
				ra_only = 1'b1;
			end
			RR_STQX: begin
				op_unit = UNIT_LS;
				ra_only = 1'b1;
			end
			RR_LNOP, RR_NOP, RR_STOP: begin
				no_regs = 1'b1; // legal but touches nothing
			end
			default: begin
				op_hit = 1'b0;
			end
		endcase
	end

	always_comb begin
		hit    = op_hit;
		unit   = op_unit;
		use_ra = 1'b0;
		use_rb = 1'b0;
		rt     = '0;
		ra     = '0;
		rb     = '0;
		imm7   = '0;
		if (op_hit && !no_regs) begin
			use_ra = 1'b1;
			rt     = instr[RT_MSB:RT_LSB];
			ra     = instr[RA_MSB:RA_LSB];
			if (ra_only) begin
				imm7 = instr[IMM7_MSB:IMM7_LSB];
			end else begin
				use_rb = 1'b1;
				rb     = instr[RB_MSB:RB_LSB];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/decode_select.sv
`timescale 1ns/10ps
`default_nettype none

module decode_select (
	input  wire logic                                   clk,
	input  wire logic                                   rst,
	// three-source group
	input  wire logic                                   rrr_hit,
	input  wire logic                                   rrr_use_ra,
	input  wire logic                                   rrr_use_rb,
	input  wire logic                                   rrr_use_rc,
	input  wire logic [spu_decode_pkg::REG_ADDR_W-1:0] rrr_rt,
	input  wire logic [spu_decode_pkg::REG_ADDR_W-1:0] rrr_ra,
	input  wire logic [spu_decode_pkg::REG_ADDR_W-1:0] rrr_rb,
	input  wire logic [spu_decode_pkg::REG_ADDR_W-1:0] rrr_rc,
	input  wire spu_decode_pkg::unit_e                  rrr_unit,
	// immediate group
	input  wire logic                                   imm_hit,
	input  wire logic                                   imm_use_ra,
	input  wire logic [spu_decode_pkg::REG_ADDR_W-1:0] imm_rt,
	input  wire logic [spu_decode_pkg::REG_ADDR_W-1:0] imm_ra,
	input  wire spu_decode_pkg::unit_e                  imm_unit,
	input  wire logic [spu_decode_pkg::IMM10_W-1:0]    imm_imm10,
	input  wire logic [spu_decode_pkg::IMM16_W-1:0]    imm_imm16,
	input  wire logic [spu_decode_pkg::IMM18_W-1:0]    imm_imm18,
	// register group
	input  wire logic                                   rr_hit,
	input  wire logic                                   rr_use_ra,
	input  wire logic                                   rr_use_rb,
	input  wire logic [spu_decode_pkg::REG_ADDR_W-1:0] rr_rt,
	input  wire logic [spu_decode_pkg::REG_ADDR_W-1:0] rr_ra,
	input  wire logic [spu_decode_pkg::REG_ADDR_W-1:0] rr_rb,
	input  wire logic [spu_decode_pkg::IMM7_W-1:0]     rr_imm7,
	input  wire spu_decode_pkg::unit_e                  rr_unit,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rt,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      ra,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rb,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rc,
	output logic                                        use_ra,
	output logic                                        use_rb,
	output logic                                        use_rc,
	output spu_decode_pkg::unit_e                       unit,
	output logic [spu_decode_pkg::IMM7_W-1:0]          imm7,
	output logic [spu_decode_pkg::IMM10_W-1:0]         imm10,
	output logic [spu_decode_pkg::IMM16_W-1:0]         imm16,
	output logic [spu_decode_pkg::IMM18_W-1:0]         imm18,
	output logic                                        legal
);
	import spu_decode_pkg::*;

	logic [REG_ADDR_W-1:0] nxt_rt;
	logic [REG_ADDR_W-1:0] nxt_ra;
	logic [REG_ADDR_W-1:0] nxt_rb;
	logic [REG_ADDR_W-1:0] nxt_rc;
	logic                  nxt_use_ra;
	logic                  nxt_use_rb;
	logic                  nxt_use_rc;
	unit_e                 nxt_unit;
	logic [IMM7_W-1:0]     nxt_imm7;
	logic [IMM10_W-1:0]    nxt_imm10;
	logic [IMM16_W-1:0]    nxt_imm16;
	logic [IMM18_W-1:0]    nxt_imm18;

	// rrr before imm before rr, unmatched fields stay zero
	always_comb begin
		nxt_rt     = '0;
		nxt_ra     = '0;
		nxt_rb     = '0;
		nxt_rc     = '0;
		nxt_use_ra = 1'b0;
		nxt_use_rb = 1'b0;
		nxt_use_rc = 1'b0;
		nxt_unit   = UNIT_NONE;
		nxt_imm7   = '0;
		nxt_imm10  = '0;
		nxt_imm16  = '0;
		nxt_imm18  = '0;
		if (rrr_hit) begin
			nxt_rt     = rrr_rt;
			nxt_ra     = rrr_ra;
			nxt_rb     = rrr_rb;
			nxt_rc     = rrr_rc;
			nxt_use_ra = rrr_use_ra;
			nxt_use_rb = rrr_use_rb;
			nxt_use_rc = rrr_use_rc;
			nxt_unit   = rrr_unit;
		end else if (imm_hit) begin
			nxt_rt     = imm_rt;
			nxt_ra     = imm_ra;
			nxt_use_ra = imm_use_ra;
			nxt_unit   = imm_unit;
			nxt_imm10  = imm_imm10;
			nxt_imm16  = imm_imm16;
			nxt_imm18  = imm_imm18;
		end else if (rr_hit) begin
			nxt_rt     = rr_rt;
			nxt_ra     = rr_ra;
			nxt_rb     = rr_rb;
			nxt_use_ra = rr_use_ra;
			nxt_use_rb = rr_use_rb;
			nxt_unit   = rr_unit;
			nxt_imm7   = rr_imm7;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rt     <= '0;
			ra     <= '0;
			rb     <= '0;
			rc     <= '0;
			use_ra <= 1'b0;
			use_rb <= 1'b0;
			use_rc <= 1'b0;
			unit   <= UNIT_NONE;
			imm7   <= '0;
			imm10  <= '0;
			imm16  <= '0;
			imm18  <= '0;
			legal  <= 1'b0;
		end else begin
			rt     <= nxt_rt;
			ra     <= nxt_ra;
			rb     <= nxt_rb;
			rc     <= nxt_rc;
			use_ra <= nxt_use_ra;
			use_rb <= nxt_use_rb;
			use_rc <= nxt_use_rc;
			unit   <= nxt_unit;
			imm7   <= nxt_imm7;
			imm10  <= nxt_imm10;
			imm16  <= nxt_imm16;
			imm18  <= nxt_imm18;
			legal  <= rrr_hit | imm_hit | rr_hit; // any format matched
		end
	end

endmodule

`default_nettype wire

//--- logic/spu_instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module spu_instr_decoder (
	input  wire logic                                   clk,
	input  wire logic                                   rst,
	input  wire logic [spu_decode_pkg::INSTR_W-1:0]    instr,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rt,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      ra,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rb,
	output logic [spu_decode_pkg::REG_ADDR_W-1:0]      rc,
	output logic                                        use_ra,
	output logic                                        use_rb,
	output logic                                        use_rc,
	output spu_decode_pkg::unit_e                       unit,
	output logic [spu_decode_pkg::IMM7_W-1:0]          imm7,
	output logic [spu_decode_pkg::IMM10_W-1:0]         imm10,
	output logic [spu_decode_pkg::IMM16_W-1:0]         imm16,
	output logic [spu_decode_pkg::IMM18_W-1:0]         imm18,
	output logic                                        legal
);
	import spu_decode_pkg::*;

	logic                  rrr_hit, rrr_use_ra, rrr_use_rb, rrr_use_rc;
	logic [REG_ADDR_W-1:0] rrr_rt, rrr_ra, rrr_rb, rrr_rc;
	unit_e                 rrr_unit;

	logic                  imm_hit, imm_use_ra;
	logic [REG_ADDR_W-1:0] imm_rt, imm_ra;
	unit_e                 imm_unit;
	logic [IMM10_W-1:0]    imm_imm10;
	logic [IMM16_W-1:0]    imm_imm16;
	logic [IMM18_W-1:0]    imm_imm18;

	logic                  rr_hit, rr_use_ra, rr_use_rb;
	logic [REG_ADDR_W-1:0] rr_rt, rr_ra, rr_rb;
	logic [IMM7_W-1:0]     rr_imm7;
	unit_e                 rr_unit;

	rrr_form_decoder u_rrr (
		.instr(instr), .hit(rrr_hit), .use_ra(rrr_use_ra), .use_rb(rrr_use_rb),
		.use_rc(rrr_use_rc), .rt(rrr_rt), .ra(rrr_ra), .rb(rrr_rb), .rc(rrr_rc),
		.unit(rrr_unit)
	);

	imm_form_decoder u_imm ( // ri18, ri10, ri16
		.instr(instr), .hit(imm_hit), .use_ra(imm_use_ra), .rt(imm_rt), .ra(imm_ra),
		.unit(imm_unit), .imm10(imm_imm10), .imm16(imm_imm16), .imm18(imm_imm18)
	);

	rr_form_decoder u_rr (
		.instr(instr), .hit(rr_hit), .use_ra(rr_use_ra), .use_rb(rr_use_rb),
		.rt(rr_rt), .ra(rr_ra), .rb(rr_rb), .imm7(rr_imm7), .unit(rr_unit)
	);

	decode_select u_sel (
		.clk(clk), .rst(rst),
		.rrr_hit(rrr_hit), .rrr_use_ra(rrr_use_ra), .rrr_use_rb(rrr_use_rb),
		.rrr_use_rc(rrr_use_rc), .rrr_rt(rrr_rt), .rrr_ra(rrr_ra), .rrr_rb(rrr_rb),
		.rrr_rc(rrr_rc), .rrr_unit(rrr_unit),
		.imm_hit(imm_hit), .imm_use_ra(imm_use_ra), .imm_rt(imm_rt), .imm_ra(imm_ra),
		.imm_unit(imm_unit), .imm_imm10(imm_imm10), .imm_imm16(imm_imm16),
		.imm_imm18(imm_imm18),
		.rr_hit(rr_hit), .rr_use_ra(rr_use_ra), .rr_use_rb(rr_use_rb), .rr_rt(rr_rt),
		.rr_ra(rr_ra), .rr_rb(rr_rb), .rr_imm7(rr_imm7), .rr_unit(rr_unit),
		.rt(rt), .ra(ra), .rb(rb), .rc(rc), .use_ra(use_ra), .use_rb(use_rb),
		.use_rc(use_rc), .unit(unit), .imm7(imm7), .imm10(imm10), .imm16(imm16),
		.imm18(imm18), .legal(legal)
	);

endmodule

`default_nettype wire

//--- verif/spu_instr_decoder_assert.sv
`timescale 1ns/10ps
`default_nettype none

module spu_instr_decoder_assert (
	input wire logic                  clk,
	input wire logic                  rst,
	input wire logic                  legal,
	input wire logic                  use_ra,
	input wire logic                  use_rb,
	input wire logic                  use_rc,
	input wire spu_decode_pkg::unit_e unit
);
	import spu_decode_pkg::*;

	reset_clears: assert property (@(posedge clk)
		rst |=> (!legal && !use_ra && !use_rb && !use_rc))
		else $error("decode outputs not cleared after a reset cycle");

	// only the three-source family reads rc
	rc_only_on_sp: assert property (@(posedge clk) disable iff (rst)
		use_rc |-> (unit == UNIT_SP))
		else $error("rc read by a unit other than sp");

	illegal_is_empty: assert property (@(posedge clk) disable iff (rst)
		!legal |-> (!use_ra && !use_rb && !use_rc && unit == UNIT_NONE))
		else $error("illegal word left register reads or a unit set");

endmodule

bind spu_instr_decoder spu_instr_decoder_assert u_decode_assert (
	.clk(clk), .rst(rst), .legal(legal), .use_ra(use_ra), .use_rb(use_rb),
	.use_rc(use_rc), .unit(unit)
);

`default_nettype wire

//--- verif/tb_spu_instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spu_instr_decoder;
	import spu_decode_pkg::*;

	localparam int DRAIN_TIMEOUT = 20;
	localparam int REPEATS       = 4; // random field sets per opcode
	localparam rr_op_e RI7_OPS [11] = '{RR_SHLHI, RR_SHLI, RR_ROTHI, RR_ROTI, RR_SHLQBII,
		RR_SHLQBYI, RR_ROTQBYI, RR_ROTQBII, RR_GBB, RR_GBH, RR_GB};

	typedef struct packed {
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] ra;
		logic [REG_ADDR_W-1:0] rb;
		logic [REG_ADDR_W-1:0] rc;
		logic                  use_ra;
		logic                  use_rb;
		logic                  use_rc;
		unit_e                 unit;
		logic [IMM7_W-1:0]     imm7;
		logic [IMM10_W-1:0]    imm10;
		logic [IMM16_W-1:0]    imm16;
		logic [IMM18_W-1:0]    imm18;
		logic                  legal;
	} dec_t;

	logic                  clk;
	logic                  rst;
	logic [INSTR_W-1:0]    instr;
	logic [REG_ADDR_W-1:0] rt, ra, rb, rc;
	logic                  use_ra, use_rb, use_rc, legal;
	unit_e                 unit;
	logic [IMM7_W-1:0]     imm7;
	logic [IMM10_W-1:0]    imm10;
	logic [IMM16_W-1:0]    imm16;
	logic [IMM18_W-1:0]    imm18;

	dec_t               exp_q[$];
	logic [INSTR_W-1:0] word_q[$];
	logic [INSTR_W-1:0] pool_op[$]; // every opcode seen, reused by the mixed stream
	int                 pool_w[$];
	int                 seed;
	int                 idx;
	string              current_test;
	int                 test_checks, test_errors, tests_passed, tests_failed;
	rrr_op_e            op4;
	ri18_op_e           op7;
	ri10_op_e           op8;
	ri16_op_e           op9;
	rr_op_e             op11;

	spu_instr_decoder dut (
		.clk(clk), .rst(rst), .instr(instr), .rt(rt), .ra(ra), .rb(rb), .rc(rc),
		.use_ra(use_ra), .use_rb(use_rb), .use_rc(use_rc), .unit(unit), .imm7(imm7),
		.imm10(imm10), .imm16(imm16), .imm18(imm18), .legal(legal)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic unit_e rr_unit(input rr_op_e op);
		case (op)
			RR_SHLH, RR_SHLHI, RR_SHL, RR_SHLI, RR_ROTH, RR_ROTHI, RR_ROT, RR_ROTI:
				return UNIT_FX2;
			RR_MPY, RR_MPYU, RR_FA, RR_FS, RR_FM, RR_AVGB, RR_CNTB: return UNIT_SP;
			RR_ABSDB, RR_SUMB, RR_CEQB: return UNIT_BYTE;
			RR_SHLQBI, RR_SHLQBII, RR_SHLQBY, RR_SHLQBYI, RR_SHLQBYBI, RR_ROTQBY,
			RR_ROTQBYI, RR_ROTQBI, RR_ROTQBII, RR_GBB, RR_GBH, RR_GB: return UNIT_PERM;
			RR_STQX: return UNIT_LS;
			RR_LNOP, RR_NOP, RR_STOP: return UNIT_NONE;
			default: return UNIT_FX1;
		endcase
	endfunction

	// expected decode straight from the format rules, shortest opcode first
	function automatic dec_t ref_decode(input logic [INSTR_W-1:0] w);
		dec_t     d;
		rrr_op_e  o4;
		ri18_op_e o7;
		ri10_op_e o8;
		ri16_op_e o9;
		rr_op_e   o11;
		d = '0;
		if ($cast(o4, w[OP4_W-1:0])) begin
			d.rt     = w[RRR_RT_MSB:RRR_RT_LSB];
			d.ra     = w[RA_MSB:RA_LSB];
			d.rb     = w[RB_MSB:RB_LSB];
			d.rc     = w[RC_MSB:RC_LSB];
			d.use_ra = 1'b1;
			d.use_rb = 1'b1;
			d.use_rc = 1'b1;
			d.unit   = UNIT_SP;
			d.legal  = 1'b1;
		end else if ($cast(o7, w[OP7_W-1:0])) begin
			d.rt    = w[RT_MSB:RT_LSB];
			d.imm18 = w[IMM18_MSB:IMM18_LSB];
			d.unit  = UNIT_FX1;
			d.legal = 1'b1;
		end else if ($cast(o8, w[OP8_W-1:0])) begin
			d.rt     = w[RT_MSB:RT_LSB];
			d.ra     = w[RA_MSB:RA_LSB];
			d.use_ra = 1'b1;
			d.imm10  = w[IMM10_MSB:IMM10_LSB];
			d.unit   = (o8 inside {RI10_LQD, RI10_STQD}) ? UNIT_LS : UNIT_FX1;
			d.legal  = 1'b1;
		end else if ($cast(o9, w[OP9_W-1:0])) begin
			d.rt    = w[RT_MSB:RT_LSB];
			d.imm16 = w[IMM16_MSB:IMM16_LSB];
			if (o9 == RI16_LQA)
				d.unit = UNIT_LS;
			else if (o9 inside {RI16_BRNZ, RI16_BRHNZ, RI16_BRZ, RI16_BRA, RI16_BR})
				d.unit = UNIT_BR;
			else
				d.unit = UNIT_FX1;
			d.legal = 1'b1;
		end else if ($cast(o11, w[OP11_W-1:0])) begin
			d.unit  = rr_unit(o11);
			d.legal = 1'b1;
			if (!(o11 inside {RR_LNOP, RR_NOP, RR_STOP})) begin
				d.rt     = w[RT_MSB:RT_LSB];
				d.ra     = w[RA_MSB:RA_LSB];
				d.use_ra = 1'b1;
				if (o11 inside {RI7_OPS, RR_CLZ, RR_CNTB, RR_STQX}) begin
					d.imm7 = w[IMM7_MSB:IMM7_LSB]; // rb field reused as immediate
				end else begin
					d.rb     = w[RB_MSB:RB_LSB];
					d.use_rb = 1'b1;
				end
			end
		end
		return d;
	endfunction

	function automatic dec_t sample_outputs();
		return {rt, ra, rb, rc, use_ra, use_rb, use_rc, unit, imm7, imm10, imm16, imm18, legal};
	endfunction

	function automatic string fmt_dec(input dec_t d);
		return {$sformatf("legal=%b unit=%0d rt=%0d ra=%0d rb=%0d rc=%0d use=%b%b%b",
			d.legal, d.unit, d.rt, d.ra, d.rb, d.rc, d.use_ra, d.use_rb, d.use_rc),
			$sformatf(" i7=%h i10=%h i16=%h i18=%h", d.imm7, d.imm10, d.imm16, d.imm18)};
	endfunction

	// random fields around a fixed opcode
	function automatic logic [INSTR_W-1:0] field_word(input logic [INSTR_W-1:0] op,
		input int width);
		logic [INSTR_W-1:0] mask;
		logic [INSTR_W-1:0] w;
		mask = (32'd1 << width) - 32'd1;
		w    = $random(seed);
		return (w & ~mask) | (op & mask);
	endfunction

	task automatic send_word(input logic [INSTR_W-1:0] w);
		@(negedge clk);
		instr = w;
		exp_q.push_back(ref_decode(w));
		word_q.push_back(w);
		test_checks++;
	endtask

	task automatic send_opcode(input logic [INSTR_W-1:0] op, input int width, input int count);
		pool_op.push_back(op);
		pool_w.push_back(width);
		repeat (count) send_word(field_word(op, width));
	endtask

	task automatic start_test(input string name);
		current_test = name;
		test_checks  = 0;
		test_errors  = 0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() > 0 && cycles < DRAIN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() > 0) begin
			$display("ERROR: %s still had %0d results outstanding after %0d cycles",
				current_test, exp_q.size(), DRAIN_TIMEOUT);
			test_errors++;
			exp_q.delete();
			word_q.delete();
		end
	endtask

	task automatic finish_test();
		wait_drain();
		if (test_errors == 0) begin
			$display("test %s: ok, %0d words", current_test, test_checks);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors in %0d words", current_test, test_errors, test_checks);
			tests_failed++;
		end
	endtask

	// compare one result per cycle once the register has settled
	initial begin
		dec_t               want;
		dec_t               got;
		logic [INSTR_W-1:0] w;
		forever begin
			@(posedge clk);
			#2;
			if (exp_q.size() > 0) begin
				want = exp_q.pop_front();
				w    = word_q.pop_front();
				got  = sample_outputs();
				assert (got == want) else begin
					$display("MISMATCH %s word %h expected %s actual %s", current_test, w,
						fmt_dec(want), fmt_dec(got));
					test_errors++;
				end
			end
		end
	end

	initial begin
		seed         = 42949;
		rst          = 1'b1;
		instr        = '0;
		tests_passed = 0;
		tests_failed = 0;

		start_test("reset");
		repeat (10) @(negedge clk);
		rst = 1'b0;
		#1;
		test_checks++;
		assert (sample_outputs() == '0) else begin
			$display("MISMATCH %s expected %s actual %s", current_test, fmt_dec('0),
				fmt_dec(sample_outputs()));
			test_errors++;
		end
		finish_test();

		start_test("rrr_opcodes");
		op4 = op4.first();
		repeat (op4.num()) begin
			send_opcode(32'(op4), OP4_W, REPEATS);
			op4 = op4.next();
		end
		finish_test();

		start_test("ri18_opcodes");
		op7 = op7.first();
		repeat (op7.num()) begin
			send_opcode(32'(op7), OP7_W, REPEATS);
			op7 = op7.next();
		end
		finish_test();

		start_test("ri10_opcodes");
		op8 = op8.first();
		repeat (op8.num()) begin
			send_opcode(32'(op8), OP8_W, REPEATS);
			op8 = op8.next();
		end
		finish_test();

		start_test("ri16_opcodes");
		op9 = op9.first();
		repeat (op9.num()) begin
			send_opcode(32'(op9), OP9_W, REPEATS);
			op9 = op9.next();
		end
		finish_test();

		start_test("rr_opcodes");
		op11 = op11.first();
		repeat (op11.num()) begin
			send_opcode(32'(op11), OP11_W, REPEATS);
			op11 = op11.next();
		end
		finish_test();

		start_test("ri7_forms");
		foreach (RI7_OPS[i])
			send_opcode(32'(RI7_OPS[i]), OP11_W, 8);
		finish_test();

		start_test("random_words");
		repeat (400) send_word($random(seed));
		finish_test();

		// legal and illegal words back to back
		start_test("mixed_stream");
		repeat (200) begin
			if ($unsigned($random(seed)) % 4 == 0) begin
				send_word($random(seed));
			end else begin
				idx = $unsigned($random(seed)) % pool_op.size();
				send_word(field_word(pool_op[idx], pool_w[idx]));
			end
		end
		finish_test();

		$display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
logic/spu_decode_pkg.sv
logic/rrr_form_decoder.sv
logic/imm_form_decoder.sv
logic/rr_form_decoder.sv
logic/decode_select.sv
logic/spu_instr_decoder.sv
verif/spu_instr_decoder_assert.sv
verif/tb_spu_instr_decoder.sv

//--- run.sh
#!/bin/sh
# build and run the decoder testbench under verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
	--top-module tb_spu_instr_decoder \
	-f list.f \
	-Mdir "$BUILD_DIR" -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG_FILE"; then
	echo "failures reported in $LOG_FILE"
	exit 1
fi
exit 0
